/* logic/qspi_xip_settings.svh */
`ifndef QSPI_XIP_SETTINGS_SVH
`define QSPI_XIP_SETTINGS_SVH

// AXI read channel widths
`define QSPI_XIP_ADDR_W 32
`define QSPI_XIP_DATA_W 32
`define QSPI_XIP_ID_W 4

// First AXI address that maps onto flash offset zero
`define QSPI_XIP_FLASH_BASE 32'h0000_1000

// Each chip select owns a window of 2**FLASH_ADDR_W bytes
`define QSPI_XIP_FLASH_ADDR_W 24
`define QSPI_XIP_NUM_CS 4

// System clocks per SPI clock half-period
`define QSPI_XIP_CLK_HALF 2

// Standard single-line read
`define QSPI_XIP_CMD_READ 8'h03

`endif

/* logic/axi_rd_pkg.sv */
`include "qspi_xip_settings.svh"

package axi_rd_pkg;

  // Transaction ID echoed on every R beat
  typedef logic [`QSPI_XIP_ID_W-1:0] axi_id_t;

  // Burst length minus one, as carried on ARLEN
  typedef logic [7:0] axi_len_t;

  // One data beat
  typedef logic [`QSPI_XIP_DATA_W-1:0] axi_data_t;

  // Only the two codes this port can return
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

endpackage

/* logic/qspi_pkg.sv */
`include "qspi_xip_settings.svh"

package qspi_pkg;

  // Which flash device a request goes to
  typedef logic [$clog2(`QSPI_XIP_NUM_CS)-1:0] cs_idx_t;

  // Byte offset inside one flash device
  typedef logic [`QSPI_XIP_FLASH_ADDR_W-1:0] flash_addr_t;

  // Read engine sequencing
  typedef enum logic [2:0] {
    PH_IDLE,
    PH_CMD,
    PH_ADDR,
    PH_DATA,
    PH_PAUSE,
    PH_ERR
  } engine_phase_t;

endpackage

/* logic/xip_req_if.sv */
`timescale 1ns/1ps
`include "qspi_xip_settings.svh"

interface xip_req_if;

  // Held request, valid stays up until take
  logic                  valid;
  axi_rd_pkg::axi_id_t   id;
  axi_rd_pkg::axi_len_t  len;
  qspi_pkg::cs_idx_t     cs;
  qspi_pkg::flash_addr_t offset;
  // Address fell below the flash window
  logic                  err;
  // Single-cycle acknowledge from the engine
  logic                  take;

  modport source (
    output valid, id, len, cs, offset, err,
    input  take
  );

  modport sink (
    input  valid, id, len, cs, offset, err,
    output take
  );

endinterface

/* logic/xip_beat_if.sv */
`timescale 1ns/1ps
`include "qspi_xip_settings.svh"

interface xip_beat_if;

  logic                 push;
  axi_rd_pkg::axi_id_t  id;
  axi_rd_pkg::axi_data_t data;
  logic                 last;
  logic                 err;
  // Response stage is holding a beat
  logic                 full;

  modport source (
    output push, id, data, last, err,
    input  full
  );

  modport sink (
    input  push, id, data, last, err,
    output full
  );

endinterface

/* logic/axi_ar_decode.sv */
`timescale 1ns/1ps
`include "qspi_xip_settings.svh"

module axi_ar_decode (
  input  logic                        s_axi_aclk,
  input  logic                        s_axi_aresetn,
  input  logic                        s_axi_arvalid_i,
  input  axi_rd_pkg::axi_id_t         s_axi_arid_i,
  input  logic [`QSPI_XIP_ADDR_W-1:0] s_axi_araddr_i,
  input  axi_rd_pkg::axi_len_t        s_axi_arlen_i,
  output logic                        s_axi_arready_o,
  xip_req_if.source                   req
);

  localparam int CS_W  = $bits(qspi_pkg::cs_idx_t);
  localparam int OFF_W = `QSPI_XIP_FLASH_ADDR_W;

  logic [`QSPI_XIP_ADDR_W-1:0] rel_addr;
  logic                        below_base;
  logic                        accept;
  logic                        held_q;
  axi_rd_pkg::axi_id_t         id_q;
  axi_rd_pkg::axi_len_t        len_q;
  qspi_pkg::cs_idx_t           cs_q;
  qspi_pkg::flash_addr_t       off_q;
  logic                        err_q;

  // Window select sits just above the per-device offset
  assign rel_addr   = s_axi_araddr_i - `QSPI_XIP_FLASH_BASE;
  assign below_base = s_axi_araddr_i < `QSPI_XIP_FLASH_BASE;

  // Single buffer, free again as soon as the engine takes it
  assign s_axi_arready_o = !held_q;
  assign accept          = s_axi_arvalid_i && !held_q;

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      held_q <= 1'b0;
    end else if (accept) begin
      held_q <= 1'b1;
    end else if (req.take) begin
      held_q <= 1'b0;
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (accept) begin
      id_q  <= s_axi_arid_i;
      len_q <= s_axi_arlen_i;
      cs_q  <= rel_addr[OFF_W +: CS_W];
      off_q <= rel_addr[OFF_W-1:0];
      err_q <= below_base;
    end
  end

  assign req.valid  = held_q;
  assign req.id     = id_q;
  assign req.len    = len_q;
  assign req.cs     = cs_q;
  assign req.offset = off_q;
  assign req.err    = err_q;

endmodule

/* logic/qspi_read_engine.sv */
`timescale 1ns/1ps
`include "qspi_xip_settings.svh"

module qspi_read_engine (
  input  logic                        s_axi_aclk,
  input  logic                        s_axi_aresetn,
  xip_req_if.sink                     req,
  xip_beat_if.source                  beat,
  output logic                        spi_clk_o,
  output logic [`QSPI_XIP_NUM_CS-1:0] spi_csn_o,
  output logic                        spi_sdo_o,
  input  logic                        spi_sdi_i
);

  localparam int HALF_W    = (`QSPI_XIP_CLK_HALF > 1) ? $clog2(`QSPI_XIP_CLK_HALF) : 1;
  localparam int WORD_BITS = `QSPI_XIP_DATA_W;
  localparam int CMD_BITS  = 8;
  // Command and address go out back to back as one 32-bit header
  localparam int HDR_BITS  = CMD_BITS + `QSPI_XIP_FLASH_ADDR_W;
  localparam int BIT_W     = $clog2(WORD_BITS);

  localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(`QSPI_XIP_CLK_HALF - 1);
  localparam logic [BIT_W-1:0]  CMD_LAST  = BIT_W'(CMD_BITS - 1);
  localparam logic [BIT_W-1:0]  HDR_LAST  = BIT_W'(HDR_BITS - 1);
  localparam logic [BIT_W-1:0]  WORD_LAST = BIT_W'(WORD_BITS - 1);

  qspi_pkg::engine_phase_t     phase_q;
  logic [HALF_W-1:0]           half_cnt_q;
  logic                        spi_clk_q;
  logic [BIT_W-1:0]            bit_cnt_q;
  axi_rd_pkg::axi_len_t        beat_cnt_q;
  logic [`QSPI_XIP_NUM_CS-1:0] csn_q;
  logic [HDR_BITS-1:0]         tx_sr_q;
  axi_rd_pkg::axi_data_t       rx_sr_q;
  axi_rd_pkg::axi_id_t         id_q;
  axi_rd_pkg::axi_len_t        len_q;

  logic spi_active;
  logic hdr_phase;
  logic start;
  logic tick;
  logic rise;
  logic fall;
  logic word_done;
  logic last_beat;
  logic push;

  assign hdr_phase  = (phase_q == qspi_pkg::PH_CMD) || (phase_q == qspi_pkg::PH_ADDR);
  assign spi_active = hdr_phase || (phase_q == qspi_pkg::PH_DATA);
  assign start      = (phase_q == qspi_pkg::PH_IDLE) && req.valid;

  // SPI clock edges, mode 0
  assign tick = spi_active && (half_cnt_q == HALF_LAST);
  assign rise = tick && !spi_clk_q;
  assign fall = tick && spi_clk_q;

  // The 32nd falling edge of a word closes it
  assign word_done = fall && (phase_q == qspi_pkg::PH_DATA) && (bit_cnt_q == WORD_LAST);
  assign last_beat = beat_cnt_q == len_q;

  always_comb begin
    push = 1'b0;
    if (!beat.full) begin
      push = word_done || (phase_q == qspi_pkg::PH_PAUSE) || (phase_q == qspi_pkg::PH_ERR);
    end
  end

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      phase_q    <= qspi_pkg::PH_IDLE;
      half_cnt_q <= '0;
      spi_clk_q  <= 1'b0;
      bit_cnt_q  <= '0;
      beat_cnt_q <= '0;
      csn_q      <= '1;
    end else begin
      if (spi_active) begin
        half_cnt_q <= tick ? '0 : half_cnt_q + 1'b1;
      end
      if (rise) begin
        spi_clk_q <= 1'b1;
      end
      if (fall) begin
        spi_clk_q <= 1'b0;
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
      if (push) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end

      case (phase_q)
        qspi_pkg::PH_IDLE: begin
          if (req.valid) begin
            beat_cnt_q <= '0;
            bit_cnt_q  <= '0;
            half_cnt_q <= '0;
            if (req.err) begin
              phase_q <= qspi_pkg::PH_ERR;
            end else begin
              phase_q <= qspi_pkg::PH_CMD;
              csn_q   <= ~(`QSPI_XIP_NUM_CS'(1) << req.cs);
            end
          end
        end
        qspi_pkg::PH_CMD: begin
          if (fall && bit_cnt_q == CMD_LAST) begin
            phase_q <= qspi_pkg::PH_ADDR;
          end
        end
        qspi_pkg::PH_ADDR: begin
          // Counter wraps to zero for the first data word
          if (fall && bit_cnt_q == HDR_LAST) begin
            phase_q <= qspi_pkg::PH_DATA;
          end
        end
        qspi_pkg::PH_DATA: begin
          if (word_done) begin
            if (beat.full) begin
              // Clock parks low, chip select stays active
              phase_q <= qspi_pkg::PH_PAUSE;
            end else if (last_beat) begin
              phase_q <= qspi_pkg::PH_IDLE;
              csn_q   <= '1;
            end
          end
        end
        qspi_pkg::PH_PAUSE: begin
          if (!beat.full) begin
            if (last_beat) begin
              phase_q <= qspi_pkg::PH_IDLE;
              csn_q   <= '1;
            end else begin
              phase_q <= qspi_pkg::PH_DATA;
            end
          end
        end
        qspi_pkg::PH_ERR: begin
          if (!beat.full && last_beat) begin
            phase_q <= qspi_pkg::PH_IDLE;
          end
        end
        default: phase_q <= qspi_pkg::PH_IDLE;
      endcase
    end
  end

  // Header shifts out on falling edges, data shifts in on rising edges
  always_ff @(posedge s_axi_aclk) begin
    if (start) begin
      tx_sr_q <= {`QSPI_XIP_CMD_READ, req.offset};
      id_q    <= req.id;
      len_q   <= req.len;
    end else if (fall) begin
      tx_sr_q <= {tx_sr_q[HDR_BITS-2:0], 1'b0};
    end
    if (rise && phase_q == qspi_pkg::PH_DATA) begin
      rx_sr_q <= {rx_sr_q[WORD_BITS-2:0], spi_sdi_i};
    end
  end

  assign req.take = start;

  assign beat.push = push;
  assign beat.id   = id_q;
  assign beat.data = (phase_q == qspi_pkg::PH_ERR) ? '0 : rx_sr_q;
  assign beat.last = last_beat;
  assign beat.err  = phase_q == qspi_pkg::PH_ERR;

  assign spi_clk_o = spi_clk_q;
  assign spi_csn_o = csn_q;
  assign spi_sdo_o = hdr_phase && tx_sr_q[HDR_BITS-1];

endmodule

/* logic/axi_r_respond.sv */
`timescale 1ns/1ps
`include "qspi_xip_settings.svh"

module axi_r_respond (
  input  logic                  s_axi_aclk,
  input  logic                  s_axi_aresetn,
  xip_beat_if.sink              beat,
  output logic                  s_axi_rvalid_o,
  output axi_rd_pkg::axi_id_t   s_axi_rid_o,
  output axi_rd_pkg::axi_data_t s_axi_rdata_o,
  output axi_rd_pkg::axi_resp_t s_axi_rresp_o,
  output logic                  s_axi_rlast_o,
  input  logic                  s_axi_rready_i
);

  localparam int NUM_BYTES = `QSPI_XIP_DATA_W / 8;

  logic                  full_q;
  axi_rd_pkg::axi_id_t   id_q;
  axi_rd_pkg::axi_data_t data_q;
  logic                  last_q;
  logic                  err_q;
  axi_rd_pkg::axi_data_t swapped;

  // First byte off the wire belongs at the lowest lane
  always_comb begin
    for (int i = 0; i < NUM_BYTES; i++) begin
      swapped[i*8 +: 8] = beat.data[(NUM_BYTES-1-i)*8 +: 8];
    end
  end

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      full_q <= 1'b0;
    end else if (beat.push) begin
      full_q <= 1'b1;
    end else if (full_q && s_axi_rready_i) begin
      full_q <= 1'b0;
    end
  end

  // Engine only pushes into an empty slot, so the beat stays put until taken
  always_ff @(posedge s_axi_aclk) begin
    if (beat.push) begin
      id_q   <= beat.id;
      data_q <= swapped;
      last_q <= beat.last;
      err_q  <= beat.err;
    end
  end

  assign beat.full = full_q;

  assign s_axi_rvalid_o = full_q;
  assign s_axi_rid_o    = id_q;
  assign s_axi_rdata_o  = data_q;
  assign s_axi_rresp_o  = err_q ? axi_rd_pkg::RESP_SLVERR : axi_rd_pkg::RESP_OKAY;
  assign s_axi_rlast_o  = last_q;

endmodule

/* logic/axi_qspi_xip.sv */
`timescale 1ns/1ps
`include "qspi_xip_settings.svh"

module axi_qspi_xip (
  input  logic                        s_axi_aclk,
  input  logic                        s_axi_aresetn,

  // AXI4 read address
  input  logic                        s_axi_arvalid_i,
  input  axi_rd_pkg::axi_id_t         s_axi_arid_i,
  input  logic [`QSPI_XIP_ADDR_W-1:0] s_axi_araddr_i,
  input  axi_rd_pkg::axi_len_t        s_axi_arlen_i,
  output logic                        s_axi_arready_o,

  // AXI4 read data
  output logic                        s_axi_rvalid_o,
  output axi_rd_pkg::axi_id_t         s_axi_rid_o,
  output axi_rd_pkg::axi_data_t       s_axi_rdata_o,
  output axi_rd_pkg::axi_resp_t       s_axi_rresp_o,
  output logic                        s_axi_rlast_o,
  input  logic                        s_axi_rready_i,

  // Serial flash, one chip select per device
  output logic                        spi_clk_o,
  output logic [`QSPI_XIP_NUM_CS-1:0] spi_csn_o,
  output logic                        spi_sdo_o,
  input  logic                        spi_sdi_i
);

  xip_req_if  u_req ();
  xip_beat_if u_beat ();

  axi_ar_decode u_decode (
    .s_axi_aclk      (s_axi_aclk),
    .s_axi_aresetn   (s_axi_aresetn),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arid_i    (s_axi_arid_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arlen_i   (s_axi_arlen_i),
    .s_axi_arready_o (s_axi_arready_o),
    .req             (u_req.source)
  );

  qspi_read_engine u_engine (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .req           (u_req.sink),
    .beat          (u_beat.source),
    .spi_clk_o     (spi_clk_o),
    .spi_csn_o     (spi_csn_o),
    .spi_sdo_o     (spi_sdo_o),
    .spi_sdi_i     (spi_sdi_i)
  );

  axi_r_respond u_respond (
    .s_axi_aclk     (s_axi_aclk),
    .s_axi_aresetn  (s_axi_aresetn),
    .beat           (u_beat.sink),
    .s_axi_rvalid_o (s_axi_rvalid_o),
    .s_axi_rid_o    (s_axi_rid_o),
    .s_axi_rdata_o  (s_axi_rdata_o),
    .s_axi_rresp_o  (s_axi_rresp_o),
    .s_axi_rlast_o  (s_axi_rlast_o),
    .s_axi_rready_i (s_axi_rready_i)
  );

endmodule

/* testbench/spi_flash_model.sv */
`timescale 1ns/1ps
`include "qspi_xip_settings.svh"

module spi_flash_model #(
  parameter int CHIP = 0
) (
  input  logic       spi_clk_i,
  input  logic       spi_csn_i,
  input  logic       spi_sdo_i,
  output wire        spi_sdi_o,
  output int         cmd_cnt_o,
  output logic       bad_cmd_o,
  output logic [7:0] cmd_byte_o
);

  int unsigned rise_cnt;
  logic [31:0] hdr_q;
  logic        out_bit;

  // Content pattern differs per chip so a wrong select shows up in the data
  function automatic logic [7:0] byte_at(input logic [23:0] off);
    return off[7:0] ^ (8'(CHIP) * 8'h11) ^ 8'h5a;
  endfunction

  initial begin
    rise_cnt   = 0;
    hdr_q      = '0;
    out_bit    = 1'b0;
    cmd_cnt_o  = 0;
    bad_cmd_o  = 1'b0;
    cmd_byte_o = '0;
  end

  // Command and address shift in on rising edges, MSB first
  always @(posedge spi_clk_i or posedge spi_csn_i) begin
    if (spi_csn_i) begin
      rise_cnt = 0;
    end else begin
      if (rise_cnt < 32) begin
        hdr_q = {hdr_q[30:0], spi_sdo_i};
      end
      if (rise_cnt == 7) begin
        cmd_cnt_o  = cmd_cnt_o + 1;
        cmd_byte_o = hdr_q[7:0];
        if (hdr_q[7:0] != `QSPI_XIP_CMD_READ) begin
          bad_cmd_o = 1'b1;
        end
      end
      rise_cnt = rise_cnt + 1;
    end
  end

  // Data leaves on falling edges once the 24-bit address is in
  always @(negedge spi_clk_i) begin
    logic [7:0]  cur;
    int unsigned idx;
    if (!spi_csn_i && rise_cnt >= 32) begin
      idx     = rise_cnt - 32;
      cur     = byte_at(hdr_q[23:0] + 24'(idx / 8));
      out_bit = cur[7 - (idx % 8)];
    end
  end

  assign spi_sdi_o = spi_csn_i ? 1'bz : out_bit;

endmodule

/* testbench/axi_qspi_xip_assertions.sv */
`timescale 1ns/1ps
`include "qspi_xip_settings.svh"

module axi_qspi_xip_assertions (
  input logic                        s_axi_aclk,
  input logic                        s_axi_aresetn,
  input logic                        spi_clk_i,
  input logic [`QSPI_XIP_NUM_CS-1:0] spi_csn_i,
  input logic                        s_axi_rvalid_i,
  input logic                        s_axi_rready_i,
  input axi_rd_pkg::axi_data_t       s_axi_rdata_i,
  input logic                        s_axi_rlast_i
);

  // Failures so far, summed into the final verdict by the testbench
  int unsigned fail_cnt = 0;

  cs_onehot: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    $onehot0(~spi_csn_i))
  else begin
    fail_cnt++;
    $error("more than one chip select low, spi_csn %h", spi_csn_i);
  end

  // Clock idles low between bursts
  clk_idle: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    (&spi_csn_i) |-> !spi_clk_i)
  else begin
    fail_cnt++;
    $error("spi_clk high with no chip selected");
  end

  r_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    (s_axi_rvalid_i && !s_axi_rready_i) |=>
      (s_axi_rvalid_i && $stable(s_axi_rdata_i) && $stable(s_axi_rlast_i)))
  else begin
    fail_cnt++;
    $error("R channel changed while stalled, rdata %h", s_axi_rdata_i);
  end

endmodule

/* testbench/tb_axi_qspi_xip.sv */
`timescale 1ns/1ps
`include "qspi_xip_settings.svh"

module tb_axi_qspi_xip;

  localparam int CLK_PERIOD  = 4;
  localparam int NUM_CS      = `QSPI_XIP_NUM_CS;
  localparam int RAND_BURSTS = 20;
  localparam logic [31:0] FLASH_BASE = `QSPI_XIP_FLASH_BASE;
  // Worst case beats over all tests, random bursts are at most 8 long
  localparam int MAX_BEATS   = 8 + 16 + 12 + 4 + RAND_BURSTS * 8;
  localparam int WATCHDOG_NS = MAX_BEATS * 64 * 4 * CLK_PERIOD + 20000;

  typedef struct packed {
    axi_rd_pkg::axi_id_t   id;
    axi_rd_pkg::axi_data_t data;
    axi_rd_pkg::axi_resp_t resp;
    logic                  last;
  } beat_t;

  logic                  s_axi_aclk = 1'b0;
  logic                  s_axi_aresetn;
  logic                  arvalid;
  axi_rd_pkg::axi_id_t   arid;
  logic [31:0]           araddr;
  axi_rd_pkg::axi_len_t  arlen;
  logic                  arready;
  logic                  rvalid;
  axi_rd_pkg::axi_id_t   rid;
  axi_rd_pkg::axi_data_t rdata;
  axi_rd_pkg::axi_resp_t rresp;
  logic                  rlast;
  logic                  rready = 1'b0;
  logic                  spi_clk;
  logic [NUM_CS-1:0]     spi_csn;
  logic                  spi_sdo;
  wire                   spi_sdi;

  int          cmd_cnt [NUM_CS];
  logic        bad_cmd [NUM_CS];
  logic [7:0]  cmd_byte [NUM_CS];
  int          exp_cmds [NUM_CS];
  beat_t       exp_q [$];
  logic [31:0] rng_state;
  logic [31:0] ready_state = 32'd25;
  logic        random_ready = 1'b0;
  int          cmp_errors = 0;
  int          chk_errors = 0;
  int          beats_checked = 0;
  int          csn_low_cycles = 0;
  int          tests_run = 0;

  always #(CLK_PERIOD / 2) s_axi_aclk = ~s_axi_aclk;

  axi_qspi_xip DUT (
    .s_axi_aclk      (s_axi_aclk),
    .s_axi_aresetn   (s_axi_aresetn),
    .s_axi_arvalid_i (arvalid),
    .s_axi_arid_i    (arid),
    .s_axi_araddr_i  (araddr),
    .s_axi_arlen_i   (arlen),
    .s_axi_arready_o (arready),
    .s_axi_rvalid_o  (rvalid),
    .s_axi_rid_o     (rid),
    .s_axi_rdata_o   (rdata),
    .s_axi_rresp_o   (rresp),
    .s_axi_rlast_o   (rlast),
    .s_axi_rready_i  (rready),
    .spi_clk_o       (spi_clk),
    .spi_csn_o       (spi_csn),
    .spi_sdo_o       (spi_sdo),
    .spi_sdi_i       (spi_sdi)
  );

  for (genvar g = 0; g < NUM_CS; g++) begin : g_flash
    spi_flash_model #(.CHIP(g)) u_flash (
      .spi_clk_i  (spi_clk),
      .spi_csn_i  (spi_csn[g]),
      .spi_sdo_i  (spi_sdo),
      .spi_sdi_o  (spi_sdi),
      .cmd_cnt_o  (cmd_cnt[g]),
      .bad_cmd_o  (bad_cmd[g]),
      .cmd_byte_o (cmd_byte[g])
    );
  end

  bind axi_qspi_xip axi_qspi_xip_assertions u_assertions (
    .s_axi_aclk     (s_axi_aclk),
    .s_axi_aresetn  (s_axi_aresetn),
    .spi_clk_i      (spi_clk_o),
    .spi_csn_i      (spi_csn_o),
    .s_axi_rvalid_i (s_axi_rvalid_o),
    .s_axi_rready_i (s_axi_rready_i),
    .s_axi_rdata_i  (s_axi_rdata_o),
    .s_axi_rlast_i  (s_axi_rlast_o)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [7:0] flash_byte(input int chip, input logic [23:0] off);
    return off[7:0] ^ (8'(chip) * 8'h11) ^ 8'h5a;
  endfunction

  // Byte i of beat n is the flash byte at offset + 4n + i
  function automatic beat_t expected_beat(input logic [31:0] addr,
                                          input axi_rd_pkg::axi_len_t len,
                                          input axi_rd_pkg::axi_id_t id, input int n);
    beat_t       b;
    logic [31:0] rel;
    b.id   = id;
    b.last = (n == int'(len));
    if (addr < FLASH_BASE) begin
      b.data = '0;
      b.resp = axi_rd_pkg::RESP_SLVERR;
    end else begin
      rel    = addr - FLASH_BASE;
      b.resp = axi_rd_pkg::RESP_OKAY;
      for (int i = 0; i < 4; i++) begin
        b.data[i*8 +: 8] = flash_byte(int'(rel[25:24]), rel[23:0] + 24'(4 * n + i));
      end
    end
    return b;
  endfunction

  task automatic read_burst(input logic [31:0] addr, input axi_rd_pkg::axi_len_t len,
                            input axi_rd_pkg::axi_id_t id);
    logic [31:0] rel;
    rel = addr - FLASH_BASE;
    for (int n = 0; n <= int'(len); n++) begin
      exp_q.push_back(expected_beat(addr, len, id, n));
    end
    if (addr >= FLASH_BASE) begin
      exp_cmds[rel[25:24]]++;
    end
    @(negedge s_axi_aclk);
    arvalid = 1'b1;
    araddr  = addr;
    arlen   = len;
    arid    = id;
    @(posedge s_axi_aclk);
    while (!arready) begin
      @(posedge s_axi_aclk);
    end
    @(negedge s_axi_aclk);
    arvalid = 1'b0;
  endtask

  task automatic drain_beats();
    while (exp_q.size() != 0) begin
      @(posedge s_axi_aclk);
    end
    repeat (4) @(posedge s_axi_aclk);
  endtask

  task automatic finish_test(input string name, input int err_mark, input int beat_mark);
    for (int c = 0; c < NUM_CS; c++) begin
      if (bad_cmd[c]) begin
        $display("Error: flash %0d cmd_byte expected %h got %h", c,
                 `QSPI_XIP_CMD_READ, cmd_byte[c]);
        chk_errors++;
      end
      if (cmd_cnt[c] != exp_cmds[c]) begin
        $display("Error: flash %0d cmd_count expected %h got %h", c, exp_cmds[c], cmd_cnt[c]);
        chk_errors++;
      end
    end
    tests_run++;
    $display("[%0d] %s: %0d beats, %0d errors", tests_run, name,
             beats_checked - beat_mark, cmp_errors + chk_errors - err_mark);
  endtask

  always @(negedge s_axi_aclk) begin
    if (random_ready) begin
      ready_state = lcg_next(ready_state);
      rready      = ready_state[20];
    end else begin
      rready = 1'b1;
    end
  end

  always @(posedge s_axi_aclk) begin
    if (spi_csn != '1) begin
      csn_low_cycles++;
    end
  end

  // Every R handshake is checked against the head of the expected queue
  always @(posedge s_axi_aclk) begin
    beat_t want;
    if (s_axi_aresetn && rvalid && rready) begin
      if (exp_q.size() == 0) begin
        $display("Error: unexpected R beat, rid %h rdata %h", rid, rdata);
        cmp_errors++;
      end else begin
        want = exp_q.pop_front();
        beats_checked++;
        if (rdata !== want.data) begin
          $display("Error: rdata expected %h got %h", want.data, rdata);
          cmp_errors++;
        end
        if (rid !== want.id) begin
          $display("Error: rid expected %h got %h", want.id, rid);
          cmp_errors++;
        end
        if (rresp !== want.resp) begin
          $display("Error: rresp expected %h got %h", want.resp, rresp);
          cmp_errors++;
        end
        if (rlast !== want.last) begin
          $display("Error: rlast expected %h got %h", want.last, rlast);
          cmp_errors++;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns with %0d beats still expected", WATCHDOG_NS, exp_q.size());
    $display("Test failed");
    $finish;
  end

  initial begin
    int                   err_mark;
    int                   beat_mark;
    int                   csn_mark;
    int                   total;
    logic [1:0]           r_cs;
    logic [23:0]          r_off;
    axi_rd_pkg::axi_len_t r_len;
    axi_rd_pkg::axi_id_t  r_id;
    s_axi_aresetn = 1'b0;
    arvalid       = 1'b0;
    arid          = '0;
    araddr        = '0;
    arlen         = '0;
    rng_state     = 32'd25;
    for (int c = 0; c < NUM_CS; c++) begin
      exp_cmds[c] = 0;
    end
    repeat (10) @(posedge s_axi_aclk);
    @(negedge s_axi_aclk);
    if (arready !== 1'b1 || rvalid !== 1'b0 || spi_csn !== '1 || spi_clk !== 1'b0) begin
      $display("Error: reset state arready %h rvalid %h spi_csn %h spi_clk %h",
               arready, rvalid, spi_csn, spi_clk);
      chk_errors++;
    end
    s_axi_aresetn = 1'b1;

    err_mark  = cmp_errors + chk_errors;
    beat_mark = beats_checked;
    for (int k = 0; k < 8; k++) begin
      read_burst(FLASH_BASE + 32'(k * 20), 8'd0, 4'(k));
    end
    drain_beats();
    finish_test("single beats chip 0", err_mark, beat_mark);

    err_mark  = cmp_errors + chk_errors;
    beat_mark = beats_checked;
    for (int k = 0; k < 4; k++) begin
      read_burst(FLASH_BASE + 32'h100 + 32'(k * 64), 8'd3, 4'(k + 8));
    end
    drain_beats();
    finish_test("bursts of four", err_mark, beat_mark);

    err_mark  = cmp_errors + chk_errors;
    beat_mark = beats_checked;
    for (int c = 1; c < NUM_CS; c++) begin
      for (int k = 0; k < 2; k++) begin
        read_burst(FLASH_BASE + (32'(c) << 24) + 32'(k * 8 + c), 8'd1, 4'(c * 2 + k));
      end
    end
    drain_beats();
    finish_test("chips 1 to 3", err_mark, beat_mark);

    // Nothing below the base may touch the flash
    err_mark  = cmp_errors + chk_errors;
    beat_mark = beats_checked;
    csn_mark  = csn_low_cycles;
    read_burst(32'h0000_0400, 8'd1, 4'hc);
    read_burst(32'h0000_0ffc, 8'd1, 4'hd);
    drain_beats();
    if (csn_low_cycles != csn_mark) begin
      $display("Error: spi_csn went low for %0d cycles during reads below the base",
               csn_low_cycles - csn_mark);
      chk_errors++;
    end
    finish_test("reads below base", err_mark, beat_mark);

    err_mark     = cmp_errors + chk_errors;
    beat_mark    = beats_checked;
    random_ready = 1'b1;
    for (int k = 0; k < RAND_BURSTS; k++) begin
      rng_state = lcg_next(rng_state);
      r_cs      = rng_state[31:30];
      r_len     = 8'(rng_state[29:27]);
      r_id      = rng_state[26:23];
      rng_state = lcg_next(rng_state);
      r_off     = rng_state[31:8];
      read_burst(FLASH_BASE + {6'b0, r_cs, r_off}, r_len, r_id);
    end
    drain_beats();
    random_ready = 1'b0;
    finish_test("random bursts with rready stalls", err_mark, beat_mark);

    total = cmp_errors + chk_errors + int'(DUT.u_assertions.fail_cnt);
    $display("Summary: %0d tests, %0d beats checked, %0d errors, %0d assertion failures",
             tests_run, beats_checked, cmp_errors + chk_errors, DUT.u_assertions.fail_cnt);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+logic
logic/axi_rd_pkg.sv
logic/qspi_pkg.sv
logic/xip_req_if.sv
logic/xip_beat_if.sv
logic/axi_ar_decode.sv
logic/qspi_read_engine.sv
logic/axi_r_respond.sv
logic/axi_qspi_xip.sv
testbench/spi_flash_model.sv
testbench/axi_qspi_xip_assertions.sv
testbench/tb_axi_qspi_xip.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module tb_axi_qspi_xip \
  -Mdir obj_dir -o tb_axi_qspi_xip

./obj_dir/tb_axi_qspi_xip +verilator+error+limit+1000 | tee sim.log

if grep -qx "Test passed" sim.log; then
  echo "Simulation finished without errors"
else
  echo "Simulation reported errors, see sim.log"
  exit 1
fi
